// ==== blimp_core.f ====
source/blimp_pkg.sv
source/blimp_intf.sv
source/fetch_unit.sv
source/decode_issue_unit.sv
source/alu_unit.sv
source/mul_unit.sv
source/writeback_commit_unit.sv
source/blimp_core.sv
sim/blimp_core_properties.sv
sim/blimp_core_tb.sv

// ==== Bender.yml ====
package:
  name: blimp_core

sources:
  - source/blimp_pkg.sv
  - source/blimp_intf.sv
  - source/fetch_unit.sv
  - source/decode_issue_unit.sv
  - source/alu_unit.sv
  - source/mul_unit.sv
  - source/writeback_commit_unit.sv
  - source/blimp_core.sv
  - target: simulation
    files:
      - sim/blimp_core_properties.sv
      - sim/blimp_core_tb.sv

// ==== sim/blimp_core_tb.sv ====
/* Testbench for the blimp core. Builds random programs in a model of
   instruction memory, runs them through an in-order ISA model and checks
   every retirement on the trace port against the model's commit list. */
module blimp_core_tb import blimp_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int mul_stages = 4;
  localparam int imem_words = 256;
  // addi r1..r7 from r0 at the start of each program
  localparam int preamble   = 7;
  // Mid-run reset test fetches its program twice
  localparam int total_instrs = (preamble + 40) + (preamble + 30) + (preamble + 40) +
                                (preamble + 80) + 2 * (preamble + 40);
  localparam int timeout_limit = total_instrs * (mul_stages + 4) + 5 * 50;

  logic        clk;
  logic        rst_n;
  logic [31:0] imem_addr;
  logic [31:0] imem_data;
  logic        trace_val;
  logic [31:0] trace_pc;
  logic [2:0]  trace_waddr;
  logic [31:0] trace_wdata;
  logic        trace_wen;

  logic [31:0] imem [imem_words];

  // Expected commit list
  logic [31:0] exp_pc    [128];
  logic [2:0]  exp_waddr [128];
  logic [31:0] exp_wdata [128];
  logic        exp_wen   [128];
  int          exp_count;
  int          exp_idx;

  logic  active;
  logic  in_reset_q;
  // Set once the last program instruction shows up on the trace
  logic  last_seen;
  int    n_errors;
  int    n_run;
  int    n_clean;
  int    cycle_count;
  string test_name;

  // Word index wraps inside the model memory
  assign imem_data = imem[imem_addr[9:2]];

  blimp_core blimp_core_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .imem_addr   (imem_addr),
    .imem_data   (imem_data),
    .trace_val   (trace_val),
    .trace_pc    (trace_pc),
    .trace_waddr (trace_waddr),
    .trace_wdata (trace_wdata),
    .trace_wen   (trace_wen)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ----------------------------------------
  // Program generation and ISA model
  // ----------------------------------------
  function automatic logic [31:0] encode(input logic [3:0] op, input logic [2:0] rd,
                                         input logic [2:0] rs1, input logic [2:0] rs2,
                                         input logic [15:0] imm);
    return {op, rd, rs1, rs2, 3'b000, imm};
  endfunction

  function automatic logic [2:0] pick_reg(input int lo, input int hi);
    return 3'(lo + ($urandom % (hi - lo + 1)));
  endfunction

  // In-order execution over the first n words of memory
  task automatic run_model(input int n);
    logic [31:0] regs [8];
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic        wen;
    for (int r = 0; r < 8; r++) begin
      regs[r] = '0;
    end
    for (int i = 0; i < n; i++) begin
      w = imem[i];
      a = regs[w[24:22]];
      b = regs[w[21:19]];
      case (w[31:28])
        op_add:  res = a + b;
        op_addi: res = a + {{16{w[15]}}, w[15:0]};
        op_mul:  res = a * b;
        default: res = '0;
      endcase
      wen = (w[31:28] inside {op_add, op_addi, op_mul}) && (w[27:25] != 3'd0);
      exp_pc[i]    = 32'(i * 4);
      exp_waddr[i] = w[27:25];
      exp_wdata[i] = res;
      exp_wen[i]   = wen;
      if (wen) begin
        regs[w[27:25]] = res;
      end
    end
    exp_count = n;
  endtask

  task automatic build_program(input int kind, input int n);
    logic [3:0] op;
    logic [2:0] rd;
    logic [2:0] rs1;
    logic [2:0] rs2;
    int         r;
    // Pad words are nops that carry their index
    for (int i = 0; i < imem_words; i++) begin
      imem[i] = {4'h0, 28'(i)};
    end
    for (int i = 1; i <= preamble; i++) begin
      imem[i-1] = encode(op_addi, 3'(i), 3'd0, 3'd0, 16'($urandom));
    end
    for (int i = 0; i < n; i++) begin
      r   = $urandom % 5;
      op  = 4'(r);
      rd  = pick_reg(0, 7);
      rs1 = pick_reg(0, 7);
      rs2 = pick_reg(0, 7);
      case (kind)
        // Chains through r1 and r2 with mostly multiplies
        2: begin
          op  = (r == 0) ? op_add : ((r == 1) ? op_addi : op_mul);
          rd  = pick_reg(1, 2);
          rs1 = pick_reg(1, 2);
          rs2 = pick_reg(1, 2);
        end
        // Half of the targets are r0
        3: begin
          if ($urandom % 2) begin
            rd = 3'd0;
          end
        end
        // mul then add on sources that are never rewritten
        4: begin
          op  = (i % 2 == 0) ? op_mul : op_add;
          rd  = pick_reg(3, 7);
          rs1 = pick_reg(1, 2);
          rs2 = pick_reg(1, 2);
        end
        default: ;
      endcase
      imem[preamble + i] = encode(op, rd, rs1, rs2, 16'($urandom));
    end
    run_model(preamble + n);
  endtask

  // ----------------------------------------
  // Sequencing
  // ----------------------------------------
  task automatic apply_reset(input int kind, input int n, input bit load);
    active = 1'b0;
    @(posedge clk);
    #1 rst_n = 1'b0;
    if (load) begin
      build_program(kind, n);
    end
    repeat (4) @(posedge clk);
    #1;
    exp_idx   = 0;
    last_seen = 1'b0;
    active    = 1'b1;
    rst_n     = 1'b1;
  endtask

  task automatic wait_commits(input int count);
    while (exp_idx < count) begin
      @(posedge clk);
    end
  endtask

  // The DUT reports the end by retiring the last program pc
  task automatic wait_last_commit();
    while (!last_seen) begin
      @(posedge clk);
    end
  endtask

  task automatic finish_test(input int errs_before);
    active = 1'b0;
    n_run++;
    if (n_errors == errs_before) begin
      n_clean++;
      $display("test %s: ok, %0d commits checked", test_name, exp_idx);
    end else begin
      $display("test %s: %0d errors", test_name, n_errors - errs_before);
    end
  endtask

  task automatic run_test(input string name, input int kind, input int n);
    int errs_before;
    errs_before = n_errors;
    test_name   = name;
    apply_reset(kind, n, 1'b1);
    wait_last_commit();
    finish_test(errs_before);
  endtask

  // Same program restarted after a reset in mid-run
  task automatic run_reset_test();
    int errs_before;
    errs_before = n_errors;
    test_name   = "reset_mid_run";
    apply_reset(0, 40, 1'b1);
    wait_commits(15);
    apply_reset(0, 40, 1'b0);
    wait_last_commit();
    finish_test(errs_before);
  endtask

  // ----------------------------------------
  // Trace monitor
  // ----------------------------------------
  task automatic check_field(input string sig, input logic [31:0] exp, input logic [31:0] got);
    if (got !== exp) begin
      n_errors++;
      $display("FAIL %s expected %h got %h (test %s, commit %0d)",
               sig, exp, got, test_name, exp_idx);
    end
  endtask

  always @(posedge clk) begin
    in_reset_q <= !rst_n;
  end

  // Each retirement against the next expected entry
  always @(negedge clk) begin
    if (in_reset_q && trace_val) begin
      n_errors++;
      $display("trace_val went high during reset in test %s", test_name);
    end
    if (active && trace_val) begin
      if (exp_idx >= exp_count) begin
        n_errors++;
        $display("commit at pc %h arrived with no expected entry left", trace_pc);
      end else begin
        check_field("trace_pc", exp_pc[exp_idx], trace_pc);
        check_field("trace_waddr", 32'(exp_waddr[exp_idx]), 32'(trace_waddr));
        check_field("trace_wdata", exp_wdata[exp_idx], trace_wdata);
        check_field("trace_wen", 32'(exp_wen[exp_idx]), 32'(trace_wen));
        exp_idx++;
      end
      if (trace_pc == exp_pc[exp_count-1]) begin
        last_seen = 1'b1;
      end
    end
  end

  // Upper bound on the whole run
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= timeout_limit) begin
      $display("run stopped after %0d cycles, test %s did not complete",
               cycle_count, test_name);
      $display("tests failed");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'hc41f363f));
    rst_n       = 1'b0;
    active      = 1'b0;
    in_reset_q  = 1'b0;
    last_seen   = 1'b0;
    exp_count   = 0;
    exp_idx     = 0;
    n_errors    = 0;
    n_run       = 0;
    n_clean     = 0;
    cycle_count = 0;
    test_name   = "startup";
    for (int i = 0; i < imem_words; i++) begin
      imem[i] = {4'h0, 28'(i)};
    end

    run_test("mixed_program", 0, 40);
    run_test("dependency_chains", 2, 30);
    run_test("register_zero", 3, 40);
    run_test("full_rob", 4, 80);
    run_reset_test();

    if (blimp_core_i.properties_i.assert_fails != 0) begin
      $display("%0d assertion failures in the bound checker",
               blimp_core_i.properties_i.assert_fails);
      n_errors += blimp_core_i.properties_i.assert_fails;
    end
    $display("summary: %0d run, %0d clean, %0d errors", n_run, n_clean, n_errors);
    if (n_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== sim/blimp_core_properties.sv ====
/* Concurrent checks on the commit trace of the blimp core.
   Bound into blimp_core; covers reset quieting, pc order of retirement
   and writes to register zero. */
module blimp_core_properties (
  input logic        clk,
  input logic        rst_n,
  input logic        trace_val,
  input logic [31:0] trace_pc,
  input logic [2:0]  trace_waddr,
  input logic        trace_wen
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [31:0] last_pc;
  logic        have_last;
  // Read by the testbench at the end of the run
  int          assert_fails = 0;

  // Last retired pc since reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      have_last <= 1'b0;
    end else if (trace_val) begin
      last_pc   <= trace_pc;
      have_last <= 1'b1;
    end
  end

  // ----------------------------------------
  // Commit stream
  // ----------------------------------------
  reset_quiet: assert property (@(posedge clk) !rst_n |=> !trace_val)
    else begin
      assert_fails++;
      $error("trace_val high after a reset edge");
    end

  // Program restarts at pc 0
  first_pc: assert property (@(posedge clk) disable iff (!rst_n)
    (trace_val && !have_last) |-> (trace_pc == 32'd0))
    else begin
      assert_fails++;
      $error("first commit after reset not at pc 0");
    end

  pc_step: assert property (@(posedge clk) disable iff (!rst_n)
    (trace_val && have_last) |-> (trace_pc == last_pc + 32'd4))
    else begin
      assert_fails++;
      $error("commit pc did not step by 4");
    end

  r0_no_write: assert property (@(posedge clk) disable iff (!rst_n)
    trace_val |-> !(trace_wen && (trace_waddr == 3'd0)))
    else begin
      assert_fails++;
      $error("commit writes register 0");
    end

endmodule

bind blimp_core blimp_core_properties properties_i (
  .clk         (clk),
  .rst_n       (rst_n),
  .trace_val   (trace_val),
  .trace_pc    (trace_pc),
  .trace_waddr (trace_waddr),
  .trace_wen   (trace_wen)
);

// ==== source/blimp_core.sv ====
/* Top level of the blimp core. Wires fetch, decode-issue, ALU,
   multiplier and writeback-commit together, with plain ports for
   instruction memory and the commit trace. */
module blimp_core #(
  parameter int p_seq_num_bits = 3,
  parameter int p_mul_stages   = 4
) (
  input  logic        clk,
  input  logic        rst_n,

  // ----------------------------------------
  // Instruction memory
  // ----------------------------------------
  output logic [31:0] imem_addr,
  input  logic [31:0] imem_data,

  // ----------------------------------------
  // Commit trace
  // ----------------------------------------
  output logic        trace_val,
  output logic [31:0] trace_pc,
  output logic [2:0]  trace_waddr,
  output logic [31:0] trace_wdata,
  output logic        trace_wen
);

  // Unit-to-unit links
  f_d_intf f_d_i ();
  d_x_intf #(.p_seq_num_bits(p_seq_num_bits)) alu_issue_i ();
  d_x_intf #(.p_seq_num_bits(p_seq_num_bits)) mul_issue_i ();
  x_w_intf #(.p_seq_num_bits(p_seq_num_bits)) alu_result_i ();
  x_w_intf #(.p_seq_num_bits(p_seq_num_bits)) mul_result_i ();
  commit_intf commit_i ();

  fetch_unit fetch_unit_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .imem_addr (imem_addr),
    .imem_data (imem_data),
    .f_d       (f_d_i)
  );

  decode_issue_unit #(
    .p_seq_num_bits (p_seq_num_bits)
  ) decode_issue_unit_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .f_d    (f_d_i),
    .alu    (alu_issue_i),
    .mul    (mul_issue_i),
    .commit (commit_i)
  );

  alu_unit alu_unit_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .issue  (alu_issue_i),
    .result (alu_result_i)
  );

  mul_unit #(
    .p_mul_stages (p_mul_stages)
  ) mul_unit_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .issue  (mul_issue_i),
    .result (mul_result_i)
  );

  writeback_commit_unit #(
    .p_seq_num_bits (p_seq_num_bits)
  ) writeback_commit_unit_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .alu    (alu_result_i),
    .mul    (mul_result_i),
    .commit (commit_i)
  );

  // Retirement stream goes straight out as the trace
  assign trace_val   = commit_i.val;
  assign trace_pc    = commit_i.pc;
  assign trace_waddr = commit_i.waddr;
  assign trace_wdata = commit_i.wdata;
  assign trace_wen   = commit_i.wen;

endmodule

// ==== source/writeback_commit_unit.sv ====
/* Writeback and commit. Results land in a reorder buffer indexed by
   sequence number, in any order; the head entry retires once filled,
   one per cycle, on the commit interface. */
module writeback_commit_unit import blimp_pkg::*; #(
  parameter int p_seq_num_bits = 3
) (
  input  logic         clk,
  input  logic         rst_n,
  x_w_intf.commit      alu,
  x_w_intf.commit      mul,
  commit_intf.producer commit
);

  localparam int rob_depth = 1 << p_seq_num_bits;

  // ----------------------------------------
  // Reorder buffer storage
  // ----------------------------------------
  logic [rob_depth-1:0]      filled;
  logic [rob_depth-1:0]      rob_wen;
  logic [pc_bits-1:0]        rob_pc    [rob_depth];
  logic [reg_addr_bits-1:0]  rob_waddr [rob_depth];
  logic [xlen-1:0]           rob_wdata [rob_depth];
  logic [p_seq_num_bits-1:0] head;
  logic                      head_ready;

  assign head_ready = filled[head];

  // Fill flags, head pointer, commit strobe
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      filled     <= '0;
      head       <= '0;
      commit.val <= 1'b0;
    end else begin
      commit.val <= head_ready;
      if (head_ready) begin
        filled[head] <= 1'b0;
        head         <= head + 1'b1;
      end
      // Two write ports, never the same entry
      if (alu.val) begin
        filled[alu.seq_num] <= 1'b1;
      end
      if (mul.val) begin
        filled[mul.seq_num] <= 1'b1;
      end
    end
  end

  // ----------------------------------------
  // Entry payload
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (alu.val) begin
      rob_pc[alu.seq_num]    <= alu.pc;
      rob_waddr[alu.seq_num] <= alu.waddr;
      rob_wdata[alu.seq_num] <= alu.wdata;
      rob_wen[alu.seq_num]   <= alu.wen;
    end
    if (mul.val) begin
      rob_pc[mul.seq_num]    <= mul.pc;
      rob_waddr[mul.seq_num] <= mul.waddr;
      rob_wdata[mul.seq_num] <= mul.wdata;
      rob_wen[mul.seq_num]   <= mul.wen;
    end
  end

  // Commit payload, held until the next retirement
  always_ff @(posedge clk) begin
    if (head_ready) begin
      commit.pc    <= rob_pc[head];
      commit.waddr <= rob_waddr[head];
      commit.wdata <= rob_wdata[head];
      // Keeps r0 at zero
      commit.wen   <= rob_wen[head] && (rob_waddr[head] != '0);
    end
  end

endmodule

// ==== source/mul_unit.sv ====
/* Pipelined multiplier. Product and tags move down a shift pipeline
   p_mul_stages deep, so a new multiply may enter every cycle and the
   result appears p_mul_stages cycles after issue. */
module mul_unit import blimp_pkg::*; #(
  parameter int p_mul_stages = 4
) (
  input  logic  clk,
  input  logic  rst_n,
  d_x_intf.exec issue,
  x_w_intf.exec result
);

  // Tag width comes from the interface
  localparam int seq_bits = $bits(issue.seq_num);

  logic [p_mul_stages-1:0]  val_q;
  logic [p_mul_stages-1:0]  wen_q;
  logic [xlen-1:0]          prod_q  [p_mul_stages];
  logic [reg_addr_bits-1:0] waddr_q [p_mul_stages];
  logic [seq_bits-1:0]      seq_q   [p_mul_stages];
  logic [pc_bits-1:0]       pc_q    [p_mul_stages];

  // ----------------------------------------
  // Valid pipeline
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      val_q <= '0;
    end else begin
      val_q[0] <= issue.val;
      for (int s = 1; s < p_mul_stages; s++) begin
        val_q[s] <= val_q[s-1];
      end
    end
  end

  // Payload shifts every cycle
  always_ff @(posedge clk) begin
    // Lower xlen bits of the product only
    prod_q[0]  <= issue.op1 * issue.op2;
    wen_q[0]   <= issue.wen;
    waddr_q[0] <= issue.waddr;
    seq_q[0]   <= issue.seq_num;
    pc_q[0]    <= issue.pc;
    for (int s = 1; s < p_mul_stages; s++) begin
      prod_q[s]  <= prod_q[s-1];
      wen_q[s]   <= wen_q[s-1];
      waddr_q[s] <= waddr_q[s-1];
      seq_q[s]   <= seq_q[s-1];
      pc_q[s]    <= pc_q[s-1];
    end
  end

  // Last stage drives writeback
  assign result.val     = val_q[p_mul_stages-1];
  assign result.wdata   = prod_q[p_mul_stages-1];
  assign result.wen     = wen_q[p_mul_stages-1];
  assign result.waddr   = waddr_q[p_mul_stages-1];
  assign result.seq_num = seq_q[p_mul_stages-1];
  assign result.pc      = pc_q[p_mul_stages-1];

endmodule

// ==== source/alu_unit.sv ====
/* Single-cycle ALU for add, add-immediate and nop.
   The result and its tags reach writeback one cycle after issue. */
module alu_unit import blimp_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  d_x_intf.exec issue,
  x_w_intf.exec result
);

  logic is_nop;

  assign is_nop = (issue.op == op_nop);

  // Strobe only
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result.val <= 1'b0;
    end else begin
      result.val <= issue.val;
    end
  end

  // ----------------------------------------
  // Result and tags
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (issue.val) begin
      // addi arrives with op2 already sign-extended
      result.wdata   <= is_nop ? '0 : issue.op1 + issue.op2;
      result.wen     <= issue.wen && !is_nop;
      result.waddr   <= issue.waddr;
      result.seq_num <= issue.seq_num;
      result.pc      <= issue.pc;
    end
  end

endmodule

// ==== source/decode_issue_unit.sv ====
/* Decode and issue. Decodes the fetched word, reads operands from the
   committed register file, stalls on hazards through a scoreboard and
   routes each instruction to the ALU or the multiplier one cycle later. */
module decode_issue_unit import blimp_pkg::*; #(
  parameter int p_seq_num_bits = 3
) (
  input  logic         clk,
  input  logic         rst_n,
  f_d_intf.decode      f_d,
  d_x_intf.issue       alu,
  d_x_intf.issue       mul,
  commit_intf.consumer commit
);

  // Decoded fields
  blimp_op_e                op;
  logic [reg_addr_bits-1:0] rd;
  logic [reg_addr_bits-1:0] rs1;
  logic [reg_addr_bits-1:0] rs2;
  logic [imm_bits-1:0]      imm;
  logic                     uses_rs1;
  logic                     uses_rs2;
  logic                     writes_rd;

  // Register file and operands
  logic [xlen-1:0] rf [num_regs];
  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;
  logic [xlen-1:0] imm_sext;

  // Scoreboard and sequence tracking
  logic [num_regs-1:0]       pending;
  logic [p_seq_num_bits-1:0] writer_seq [num_regs];
  logic [p_seq_num_bits-1:0] tail_seq;
  logic [p_seq_num_bits-1:0] head_seq;
  logic [p_seq_num_bits:0]   in_flight;

  logic raw_hazard;
  logic commit_hazard;
  logic rob_full;
  logic accept;

  // Issue registers shared by both pipes
  logic                      alu_val_q;
  logic                      mul_val_q;
  blimp_op_e                 op_q;
  logic [xlen-1:0]           op1_q;
  logic [xlen-1:0]           op2_q;
  logic [reg_addr_bits-1:0]  waddr_q;
  logic                      wen_q;
  logic [p_seq_num_bits-1:0] seq_q;
  logic [pc_bits-1:0]        pc_q;

  // ----------------------------------------
  // Decode
  // ----------------------------------------
  assign op        = decode_op(f_d.inst[op_msb:op_lsb]);
  assign rd        = f_d.inst[rd_msb:rd_lsb];
  assign rs1       = f_d.inst[rs1_msb:rs1_lsb];
  assign rs2       = f_d.inst[rs2_msb:rs2_lsb];
  assign imm       = f_d.inst[imm_msb:imm_lsb];
  assign imm_sext  = {{(xlen - imm_bits){imm[imm_bits-1]}}, imm};
  // addi and nop never look at rs2
  assign uses_rs1  = (op != op_nop);
  assign uses_rs2  = (op == op_add) || (op == op_mul);
  // No tracking for r0 targets
  assign writes_rd = (op != op_nop) && (rd != '0);

  // r0 reads as zero
  assign rs1_data  = (rs1 == '0) ? '0 : rf[rs1];
  assign rs2_data  = (rs2 == '0) ? '0 : rf[rs2];

  // ----------------------------------------
  // Stall logic
  // ----------------------------------------
  assign raw_hazard    = (uses_rs1 && pending[rs1]) || (uses_rs2 && pending[rs2]);
  // Register file not yet updated in the commit cycle
  assign commit_hazard = commit.val && commit.wen &&
                         ((uses_rs1 && (commit.waddr == rs1)) ||
                          (uses_rs2 && (commit.waddr == rs2)));
  // Count reaches exactly the depth when full
  assign rob_full      = in_flight[p_seq_num_bits];
  assign f_d.rdy       = !(raw_hazard || commit_hazard || rob_full);
  assign accept        = f_d.val && f_d.rdy;

  // Written at the commit edge
  always_ff @(posedge clk) begin
    if (commit.val && commit.wen) begin
      rf[commit.waddr] <= commit.wdata;
    end
  end

  // ----------------------------------------
  // Scoreboard, counters, issue strobes
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pending   <= '0;
      tail_seq  <= '0;
      head_seq  <= '0;
      in_flight <= '0;
      alu_val_q <= 1'b0;
      mul_val_q <= 1'b0;
    end else begin
      // Commits arrive in order, so head_seq names the retiring entry
      if (commit.val) begin
        head_seq <= head_seq + 1'b1;
        for (int r = 0; r < num_regs; r++) begin
          if (pending[r] && (writer_seq[r] == head_seq)) begin
            pending[r] <= 1'b0;
          end
        end
      end
      // Younger writer wins over a same-cycle clear
      if (accept) begin
        tail_seq <= tail_seq + 1'b1;
        if (writes_rd) begin
          pending[rd] <= 1'b1;
        end
      end
      case ({accept, commit.val})
        2'b10:   in_flight <= in_flight + 1'b1;
        2'b01:   in_flight <= in_flight - 1'b1;
        default: in_flight <= in_flight;
      endcase
      alu_val_q <= accept && (op != op_mul);
      mul_val_q <= accept && (op == op_mul);
    end
  end

  // Youngest writer per register
  always_ff @(posedge clk) begin
    if (accept && writes_rd) begin
      writer_seq[rd] <= tail_seq;
    end
  end

  // Operand capture, immediate already extended
  always_ff @(posedge clk) begin
    if (accept) begin
      op_q    <= op;
      op1_q   <= rs1_data;
      op2_q   <= (op == op_addi) ? imm_sext : rs2_data;
      waddr_q <= rd;
      wen_q   <= writes_rd;
      seq_q   <= tail_seq;
      pc_q    <= f_d.pc;
    end
  end

  // ----------------------------------------
  // Issue ports
  // ----------------------------------------
  assign alu.val     = alu_val_q;
  assign alu.op      = op_q;
  assign alu.op1     = op1_q;
  assign alu.op2     = op2_q;
  assign alu.waddr   = waddr_q;
  assign alu.wen     = wen_q;
  assign alu.seq_num = seq_q;
  assign alu.pc      = pc_q;

  assign mul.val     = mul_val_q;
  assign mul.op      = op_q;
  assign mul.op1     = op1_q;
  assign mul.op2     = op2_q;
  assign mul.waddr   = waddr_q;
  assign mul.wen     = wen_q;
  assign mul.seq_num = seq_q;
  assign mul.pc      = pc_q;

endmodule

// ==== source/fetch_unit.sv ====
/* Fetch unit. Holds the program counter, presents it to instruction
   memory and hands the returned word to decode together with its pc. */
module fetch_unit import blimp_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,

  // Instruction memory, data returns in the same cycle
  output logic [pc_bits-1:0]   imem_addr,
  input  logic [inst_bits-1:0] imem_data,

  f_d_intf.fetch               f_d
);

  logic [pc_bits-1:0] pc;
  logic               val_q;
  logic               xfer;

  // Handshake with decode
  assign xfer = f_d.val && f_d.rdy;

  // ----------------------------------------
  // PC register
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc    <= '0;
      val_q <= 1'b0;
    end else begin
      // Always something to offer once out of reset
      val_q <= 1'b1;
      // Hold pc while decode stalls
      if (xfer) begin
        pc <= pc + pc_step;
      end
    end
  end

  // ----------------------------------------
  // Outputs
  // ----------------------------------------
  assign imem_addr = pc;

  // Memory word is stable while pc is held
  assign f_d.val   = val_q;
  assign f_d.inst  = imem_data;
  assign f_d.pc    = pc;

endmodule

// ==== source/blimp_intf.sv ====
/* Interfaces between the units of the blimp core.
   Fetch to decode has a valid/ready handshake; the execute and commit
   paths carry a one-cycle valid strobe with no back-pressure. */

// ----------------------------------------
// Fetch to decode
// ----------------------------------------
interface f_d_intf import blimp_pkg::*; ();
  logic                 val;
  logic                 rdy;
  logic [inst_bits-1:0] inst;
  logic [pc_bits-1:0]   pc;

  modport fetch  (output val, inst, pc, input rdy);
  modport decode (input val, inst, pc, output rdy);
endinterface

// ----------------------------------------
// Decode to execute
// ----------------------------------------
interface d_x_intf import blimp_pkg::*; #(
  parameter int p_seq_num_bits = 3
) ();
  logic                      val;
  blimp_op_e                 op;
  logic [xlen-1:0]           op1;
  logic [xlen-1:0]           op2;
  logic [reg_addr_bits-1:0]  waddr;
  logic                      wen;
  logic [p_seq_num_bits-1:0] seq_num;
  logic [pc_bits-1:0]        pc;

  modport issue (output val, op, op1, op2, waddr, wen, seq_num, pc);
  modport exec  (input val, op, op1, op2, waddr, wen, seq_num, pc);
endinterface

// ----------------------------------------
// Execute to writeback
// ----------------------------------------
interface x_w_intf import blimp_pkg::*; #(
  parameter int p_seq_num_bits = 3
) ();
  logic                      val;
  logic [xlen-1:0]           wdata;
  logic [reg_addr_bits-1:0]  waddr;
  logic                      wen;
  logic [p_seq_num_bits-1:0] seq_num;
  logic [pc_bits-1:0]        pc;

  modport exec   (output val, wdata, waddr, wen, seq_num, pc);
  modport commit (input val, wdata, waddr, wen, seq_num, pc);
endinterface

// In-order retirement, also copied to the trace port
interface commit_intf import blimp_pkg::*; ();
  logic                     val;
  logic [pc_bits-1:0]       pc;
  logic [reg_addr_bits-1:0] waddr;
  logic [xlen-1:0]          wdata;
  logic                     wen;

  modport producer (output val, pc, waddr, wdata, wen);
  modport consumer (input val, pc, waddr, wdata, wen);
endinterface

// ==== source/blimp_pkg.sv ====
/* Shared definitions for the blimp core.
   Holds the opcode encoding, instruction field positions and datapath
   widths. RTL units and the testbench pull these in by wildcard import. */
package blimp_pkg;

  // ----------------------------------------
  // Datapath widths
  // ----------------------------------------
  localparam int xlen          = 32;
  localparam int inst_bits     = 32;
  localparam int num_regs      = 8;
  localparam int reg_addr_bits = 3;
  localparam int pc_bits       = 32;
  localparam int imm_bits      = 16;

  // PC steps one word per instruction
  localparam logic [pc_bits-1:0] pc_step = 32'd4;

  // ----------------------------------------
  // Instruction fields
  // ----------------------------------------
  localparam int op_msb  = 31;
  localparam int op_lsb  = 28;
  localparam int rd_msb  = 27;
  localparam int rd_lsb  = 25;
  localparam int rs1_msb = 24;
  localparam int rs1_lsb = 22;
  localparam int rs2_msb = 21;
  localparam int rs2_lsb = 19;
  localparam int imm_msb = 15;
  localparam int imm_lsb = 0;

  // Opcode field values
  typedef enum logic [3:0] {
    op_nop  = 4'h0,
    op_add  = 4'h1,
    op_addi = 4'h2,
    op_mul  = 4'h3
  } blimp_op_e;

  // Undefined encodings fall back to nop
  function automatic blimp_op_e decode_op(input logic [3:0] bits);
    case (bits)
      4'h1:    return op_add;
      4'h2:    return op_addi;
      4'h3:    return op_mul;
      default: return op_nop;
    endcase
  endfunction

endpackage
